// File: lc3_defines.svh
`ifndef LC3_DEFINES_SVH
`define LC3_DEFINES_SVH

// Word and address width
`define LC3_WORD_W 16

// General register file
`define LC3_REG_CNT 8
`define LC3_REG_AW  3

// First instruction address after reset
`define LC3_RESET_PC 16'h3000

// Instruction field widths for sign extension
`define LC3_IMM5_W 5
`define LC3_OFF9_W 9
`define LC3_OFF6_W 6 // Low field under BaseR in JMP/RET

// Opcode field position
`define LC3_OPC_LSB 12
`define LC3_OPC_W   4

`endif

// File: lc3Pkg.sv
`default_nettype none

package lc3Pkg;

    // All sixteen LC-3 opcodes, only a subset is executed
    typedef enum logic [3:0] {
        opBr   = 4'h0,
        opAdd  = 4'h1,
        opLd   = 4'h2,
        opSt   = 4'h3,
        opJsr  = 4'h4,
        opAnd  = 4'h5,
        opLdr  = 4'h6,
        opStr  = 4'h7,
        opRti  = 4'h8,
        opNot  = 4'h9,
        opLdi  = 4'hA,
        opSti  = 4'hB,
        opJmp  = 4'hC,
        opRes  = 4'hD,
        opLea  = 4'hE,
        opTrap = 4'hF
    } opcodeE;

    // Sequencer states, one per cycle
    typedef enum logic [4:0] {
        stFetch, stFetchReq, stFetchWait, stLoadIr, stDecode,
        stOperate, stLea, stBranchTaken, stJump,
        stAddrCalc, stReadReq, stReadWait, stLoadReg,
        stStoreData, stWriteReq, stWriteWait
    } stateE;

    typedef enum logic [1:0] {
        aluAdd, aluAnd, aluNot, aluPassB
    } aluOpE;

    // Single driver of the internal bus
    typedef enum logic [1:0] {
        busPc, busAlu, busAddrAdder, busMdr
    } busSrcE;

    typedef enum logic [1:0] {
        pcIncrement, pcAddrAdder, pcBus
    } pcSrcE;

endpackage

`default_nettype wire

// File: lc3RegFile.sv
`default_nettype none
`timescale 1ns/100ps

`include "lc3_defines.svh"

module lc3RegFile (
    input  wire                     i_Clk,
    input  wire                     i_arstN,
    input  wire                     i_we,
    input  wire [`LC3_REG_AW-1:0]   i_wAddr,
    input  wire [`LC3_WORD_W-1:0]   i_wData,
    input  wire [`LC3_REG_AW-1:0]   i_rAddrA,
    input  wire [`LC3_REG_AW-1:0]   i_rAddrB,
    output logic [`LC3_WORD_W-1:0]  o_rDataA,
    output logic [`LC3_WORD_W-1:0]  o_rDataB
);

    logic [`LC3_WORD_W-1:0] regs [0:`LC3_REG_CNT-1];

    // R0..R7 start at zero
    always_ff @(posedge i_Clk or negedge i_arstN)
    begin
        if (!i_arstN)
        begin
            for (int i = 0; i < `LC3_REG_CNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_we)
        begin
            regs[i_wAddr] <= i_wData;
        end
    end

    assign o_rDataA = regs[i_rAddrA]; // SR1 / BaseR
    assign o_rDataB = regs[i_rAddrB]; // SR2 or store source

endmodule

`default_nettype wire

// File: lc3Datapath.sv
`default_nettype none
`timescale 1ns/100ps

`include "lc3_defines.svh"

module lc3Datapath import lc3Pkg::*; (
    input  wire                     i_Clk,
    input  wire                     i_arstN,
    input  wire                     i_ldPc,
    input  wire                     i_ldIr,
    input  wire                     i_ldMar,
    input  wire                     i_ldMdr,
    input  wire                     i_ldReg,
    input  wire                     i_ldCc,
    input  wire                     i_mdrFromMem,
    input  busSrcE                  i_busSrc,
    input  pcSrcE                   i_pcSrc,
    input  aluOpE                   i_aluOp,
    input  wire [`LC3_WORD_W-1:0]   i_memRData,
    output opcodeE                  o_opcode,
    output logic                    o_ben,
    output logic [`LC3_WORD_W-1:0]  o_mar,
    output logic [`LC3_WORD_W-1:0]  o_mdr
);

    logic [`LC3_WORD_W-1:0] pc;
    logic [`LC3_WORD_W-1:0] ir;
    logic [`LC3_WORD_W-1:0] mar;
    logic [`LC3_WORD_W-1:0] mdr;
    logic                   flagN;
    logic                   flagZ;
    logic                   flagP;

    logic [`LC3_WORD_W-1:0] bus;
    logic [`LC3_WORD_W-1:0] aluOut;
    logic [`LC3_WORD_W-1:0] aluB;
    logic [`LC3_WORD_W-1:0] addrBase;
    logic [`LC3_WORD_W-1:0] addrOff;
    logic [`LC3_WORD_W-1:0] addrSum;
    logic [`LC3_WORD_W-1:0] pcNext;
    logic [`LC3_WORD_W-1:0] imm5;
    logic [`LC3_WORD_W-1:0] off9;
    logic [`LC3_WORD_W-1:0] rDataA;
    logic [`LC3_WORD_W-1:0] rDataB;
    logic [`LC3_REG_AW-1:0] rAddrA;
    logic [`LC3_REG_AW-1:0] rAddrB;
    logic [`LC3_REG_AW-1:0] dstReg;
    opcodeE                 opcode;

    // Field decode from IR
    assign opcode = opcodeE'(ir[`LC3_OPC_LSB +: `LC3_OPC_W]);
    assign dstReg = ir[11:9];
    assign rAddrA = ir[`LC3_OFF6_W +: `LC3_REG_AW]; // SR1 and BaseR sit above the 6-bit field
    assign rAddrB = (opcode == opSt) ? ir[11:9] : ir[2:0];

    assign imm5 = {{(`LC3_WORD_W-`LC3_IMM5_W){ir[`LC3_IMM5_W-1]}}, ir[`LC3_IMM5_W-1:0]};
    assign off9 = {{(`LC3_WORD_W-`LC3_OFF9_W){ir[`LC3_OFF9_W-1]}}, ir[`LC3_OFF9_W-1:0]};

    lc3RegFile u_regFile (
        .i_Clk    (i_Clk),
        .i_arstN  (i_arstN),
        .i_we     (i_ldReg),
        .i_wAddr  (dstReg),
        .i_wData  (bus),
        .i_rAddrA (rAddrA),
        .i_rAddrB (rAddrB),
        .o_rDataA (rDataA),
        .o_rDataB (rDataB)
    );

    // IR[5] picks imm5 for ADD and AND
    assign aluB = ir[5] ? imm5 : rDataB;

    always_comb
    begin
        case (i_aluOp)
            aluAdd:  aluOut = rDataA + aluB;
            aluAnd:  aluOut = rDataA & aluB;
            aluNot:  aluOut = ~rDataA;
            default: aluOut = rDataB; // Store source straight from port B
        endcase
    end

    // JMP uses BaseR + 0, everything else is PC-relative
    assign addrBase = (opcode == opJmp) ? rDataA : pc;
    assign addrOff  = (opcode == opJmp) ? '0 : off9;
    assign addrSum  = addrBase + addrOff;

    always_comb
    begin
        case (i_busSrc)
            busPc:        bus = pc;
            busAlu:       bus = aluOut;
            busAddrAdder: bus = addrSum;
            default:      bus = mdr;
        endcase
    end

    always_comb
    begin
        case (i_pcSrc)
            pcAddrAdder: pcNext = addrSum;
            pcBus:       pcNext = bus;
            default:     pcNext = pc + 1'b1;
        endcase
    end

    always_ff @(posedge i_Clk or negedge i_arstN)
    begin
        if (!i_arstN)
        begin
            pc    <= `LC3_RESET_PC;
            ir    <= '0;
            flagN <= 1'b0;
            flagZ <= 1'b1;
            flagP <= 1'b0;
        end
        else
        begin
            if (i_ldPc)
            begin
                pc <= pcNext;
            end
            if (i_ldIr)
            begin
                ir <= bus;
            end
            if (i_ldCc) // Flags follow the value written to DR
            begin
                flagN <= bus[`LC3_WORD_W-1];
                flagZ <= (bus == '0);
                flagP <= !bus[`LC3_WORD_W-1] && (bus != '0);
            end
        end
    end

    // Memory address and data registers
    always_ff @(posedge i_Clk)
    begin
        if (i_ldMar)
        begin
            mar <= bus;
        end
        if (i_ldMdr)
        begin
            mdr <= i_mdrFromMem ? i_memRData : bus;
        end
    end

    assign o_ben    = (ir[11] & flagN) | (ir[10] & flagZ) | (ir[9] & flagP);
    assign o_opcode = opcode;
    assign o_mar    = mar;
    assign o_mdr    = mdr;

endmodule

`default_nettype wire

// File: lc3Control.sv
`default_nettype none
`timescale 1ns/100ps

`include "lc3_defines.svh"

module lc3Control import lc3Pkg::*; (
    input  wire     i_Clk,
    input  wire     i_arstN,
    input  opcodeE  i_opcode,
    input  wire     i_ben,
    input  wire     i_memRdy,
    output logic    o_memReq,
    output logic    o_memWe,
    output logic    o_ldPc,
    output logic    o_ldIr,
    output logic    o_ldMar,
    output logic    o_ldMdr,
    output logic    o_ldReg,
    output logic    o_ldCc,
    output logic    o_mdrFromMem,
    output busSrcE  o_busSrc,
    output pcSrcE   o_pcSrc,
    output aluOpE   o_aluOp
);

    stateE state;
    stateE stateNext;

    always_ff @(posedge i_Clk or negedge i_arstN)
    begin
        if (!i_arstN)
        begin
            state <= stFetch;
        end
        else
        begin
            state <= stateNext;
        end
    end

    always_comb
    begin
        stateNext = state;
        case (state)
            stFetch:     stateNext = stFetchReq;
            stFetchReq:  stateNext = stFetchWait;
            stFetchWait:
            begin
                if (i_memRdy)
                begin
                    stateNext = stLoadIr;
                end
            end
            stLoadIr:    stateNext = stDecode;
            stDecode:
            begin
                case (i_opcode)
                    opAdd, opAnd, opNot: stateNext = stOperate;
                    opLea:               stateNext = stLea;
                    opJmp:               stateNext = stJump;
                    opLd, opSt:          stateNext = stAddrCalc;
                    opBr:                stateNext = i_ben ? stBranchTaken : stFetch;
                    default:             stateNext = stFetch; // Unsupported ops are no-ops
                endcase
            end
            stAddrCalc:  stateNext = (i_opcode == opSt) ? stStoreData : stReadReq;
            stReadReq:   stateNext = stReadWait;
            stReadWait:
            begin
                if (i_memRdy)
                begin
                    stateNext = stLoadReg;
                end
            end
            stStoreData: stateNext = stWriteReq;
            stWriteReq:  stateNext = stWriteWait;
            stWriteWait:
            begin
                if (i_memRdy)
                begin
                    stateNext = stFetch;
                end
            end
            default:     stateNext = stFetch; // Operate, Lea, BranchTaken, Jump, LoadReg
        endcase
    end

    // Datapath controls, idle unless the state asks
    always_comb
    begin
        o_memReq     = 1'b0;
        o_memWe      = 1'b0;
        o_ldPc       = 1'b0;
        o_ldIr       = 1'b0;
        o_ldMar      = 1'b0;
        o_ldMdr      = 1'b0;
        o_ldReg      = 1'b0;
        o_ldCc       = 1'b0;
        o_mdrFromMem = 1'b0;
        o_busSrc     = busPc;
        o_pcSrc      = pcIncrement;
        o_aluOp      = aluAdd;
        case (state)
            stFetch:
            begin
                o_busSrc = busPc; // MAR <- PC, PC <- PC + 1
                o_ldMar  = 1'b1;
                o_ldPc   = 1'b1;
            end
            stFetchReq, stReadReq:
            begin
                o_memReq = 1'b1;
            end
            stFetchWait, stReadWait:
            begin
                // Read data is only valid in the reply cycle
                o_mdrFromMem = 1'b1;
                o_ldMdr      = i_memRdy;
            end
            stLoadIr:
            begin
                o_busSrc = busMdr;
                o_ldIr   = 1'b1;
            end
            stOperate:
            begin
                o_busSrc = busAlu;
                o_ldReg  = 1'b1;
                o_ldCc   = 1'b1;
                case (i_opcode)
                    opAnd:   o_aluOp = aluAnd;
                    opNot:   o_aluOp = aluNot;
                    default: o_aluOp = aluAdd;
                endcase
            end
            stLea:
            begin
                o_busSrc = busAddrAdder; // No CC update for LEA
                o_ldReg  = 1'b1;
            end
            stBranchTaken:
            begin
                o_pcSrc = pcAddrAdder;
                o_ldPc  = 1'b1;
            end
            stJump:
            begin
                o_busSrc = busAddrAdder; // BaseR + 0
                o_pcSrc  = pcBus;
                o_ldPc   = 1'b1;
            end
            stAddrCalc:
            begin
                o_busSrc = busAddrAdder;
                o_ldMar  = 1'b1;
            end
            stLoadReg:
            begin
                o_busSrc = busMdr;
                o_ldReg  = 1'b1;
                o_ldCc   = 1'b1;
            end
            stStoreData:
            begin
                o_busSrc = busAlu; // MDR <- SR
                o_aluOp  = aluPassB;
                o_ldMdr  = 1'b1;
            end
            stWriteReq:
            begin
                o_memReq = 1'b1;
                o_memWe  = 1'b1;
            end
            stWriteWait:
            begin
                o_memWe = 1'b1; // Held until the write is acknowledged
            end
            default:
            begin
                o_busSrc = busPc;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: lc3Core.sv
`default_nettype none
`timescale 1ns/100ps

`include "lc3_defines.svh"

module lc3Core import lc3Pkg::*; (
    input  wire                     i_Clk,
    input  wire                     i_arstN,
    input  wire                     i_memRdy,
    input  wire [`LC3_WORD_W-1:0]   i_memRData,
    output logic                    o_memReq,
    output logic                    o_memWe,
    output logic [`LC3_WORD_W-1:0]  o_memAddr,
    output logic [`LC3_WORD_W-1:0]  o_memWData
);

    logic   ldPc;
    logic   ldIr;
    logic   ldMar;
    logic   ldMdr;
    logic   ldReg;
    logic   ldCc;
    logic   mdrFromMem;
    logic   ben;
    busSrcE busSrc;
    pcSrcE  pcSrc;
    aluOpE  aluOp;
    opcodeE opcode;

    lc3Control u_control (
        .i_Clk        (i_Clk),
        .i_arstN      (i_arstN),
        .i_opcode     (opcode),
        .i_ben        (ben),
        .i_memRdy     (i_memRdy),
        .o_memReq     (o_memReq),
        .o_memWe      (o_memWe),
        .o_ldPc       (ldPc),
        .o_ldIr       (ldIr),
        .o_ldMar      (ldMar),
        .o_ldMdr      (ldMdr),
        .o_ldReg      (ldReg),
        .o_ldCc       (ldCc),
        .o_mdrFromMem (mdrFromMem),
        .o_busSrc     (busSrc),
        .o_pcSrc      (pcSrc),
        .o_aluOp      (aluOp)
    );

    // MAR and MDR drive the memory pins directly
    lc3Datapath u_datapath (
        .i_Clk        (i_Clk),
        .i_arstN      (i_arstN),
        .i_ldPc       (ldPc),
        .i_ldIr       (ldIr),
        .i_ldMar      (ldMar),
        .i_ldMdr      (ldMdr),
        .i_ldReg      (ldReg),
        .i_ldCc       (ldCc),
        .i_mdrFromMem (mdrFromMem),
        .i_busSrc     (busSrc),
        .i_pcSrc      (pcSrc),
        .i_aluOp      (aluOp),
        .i_memRData   (i_memRData),
        .o_opcode     (opcode),
        .o_ben        (ben),
        .o_mar        (o_memAddr),
        .o_mdr        (o_memWData)
    );

endmodule

`default_nettype wire

// File: lc3Core_properties.sv
`default_nettype none
`timescale 1ns/100ps

`include "lc3_defines.svh"

module lc3CoreProperties (
    input wire                    i_Clk,
    input wire                    i_arstN,
    input wire                    i_memReq,
    input wire                    i_memRdy,
    input wire [`LC3_WORD_W-1:0]  i_memAddr
);

    logic reqOpen; // Request issued, reply not yet seen

    always_ff @(posedge i_Clk or negedge i_arstN)
    begin
        if (!i_arstN)
        begin
            reqOpen <= 1'b0;
        end
        else if (i_memReq)
        begin
            reqOpen <= 1'b1;
        end
        else if (i_memRdy)
        begin
            reqOpen <= 1'b0;
        end
    end

    reqIsStrobe: assert property (@(posedge i_Clk) disable iff (!i_arstN)
        i_memReq |=> !i_memReq)
        else $error("memory request high in two consecutive cycles");

    oneInFlight: assert property (@(posedge i_Clk) disable iff (!i_arstN)
        i_memReq |-> !reqOpen)
        else $error("new memory request before the reply to the last one");

    addrStable: assert property (@(posedge i_Clk) disable iff (!i_arstN)
        reqOpen |-> $stable(i_memAddr))
        else $error("memory address changed while a request was open");

endmodule

bind lc3Core lc3CoreProperties u_props (
    .i_Clk     (i_Clk),
    .i_arstN   (i_arstN),
    .i_memReq  (o_memReq),
    .i_memRdy  (i_memRdy),
    .i_memAddr (o_memAddr)
);

`default_nettype wire

// File: lc3CoreTb.sv
`default_nettype none
`timescale 1ns/100ps

`include "lc3_defines.svh"

module lc3CoreTb;

    localparam int ClkPeriod     = 10;
    localparam int TestCnt       = 9;
    localparam int CyclesPerTest = 400; // Worst case for the longest program at latency 4
    localparam logic [`LC3_WORD_W-1:0] StoreBase  = 16'h3040;
    localparam logic [`LC3_WORD_W-1:0] DataAddr   = 16'h3030;
    localparam logic [`LC3_WORD_W-1:0] JumpTarget = 16'h3020;

    logic                   i_Clk;
    logic                   i_arstN    = 1'b0;
    logic                   i_memRdy   = 1'b0;
    logic [`LC3_WORD_W-1:0] i_memRData = '0;
    wire                    o_memReq;
    wire                    o_memWe;
    wire  [`LC3_WORD_W-1:0] o_memAddr;
    wire  [`LC3_WORD_W-1:0] o_memWData;

    // Memory model and its request log
    logic [`LC3_WORD_W-1:0] mem [0:65535];
    logic [`LC3_WORD_W-1:0] wrAddrQ [$];
    logic [`LC3_WORD_W-1:0] wrDataQ [$];
    logic [`LC3_WORD_W-1:0] rdAddrQ [$];
    logic                   busy     = 1'b0;
    logic                   reqWe    = 1'b0;
    logic [`LC3_WORD_W-1:0] reqAddr  = '0;
    logic [`LC3_WORD_W-1:0] reqWData = '0;
    int                     waitCnt  = 0;
    logic                   randLat  = 1'b0;
    logic [31:0]            lcgState = 32'd78851;

    logic [`LC3_WORD_W-1:0] loadPc;
    int                     errCount   = 0;
    int                     errAtStart = 0;
    int                     testCnt    = 0;
    int                     failCnt    = 0;

    lc3Core uut (
        .i_Clk      (i_Clk),
        .i_arstN    (i_arstN),
        .i_memRdy   (i_memRdy),
        .i_memRData (i_memRData),
        .o_memReq   (o_memReq),
        .o_memWe    (o_memWe),
        .o_memAddr  (o_memAddr),
        .o_memWData (o_memWData)
    );

    initial
    begin
        i_Clk = 1'b0;
        forever #(ClkPeriod / 2) i_Clk = ~i_Clk;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Each request gets one reply 1 to 4 cycles later
    always @(negedge i_Clk)
    begin
        i_memRdy = 1'b0;
        if (!i_arstN)
        begin
            busy = 1'b0;
        end
        else
        begin
            if (busy)
            begin
                waitCnt = waitCnt - 1;
                if (waitCnt == 0)
                begin
                    busy     = 1'b0;
                    i_memRdy = 1'b1;
                    if (reqWe)
                    begin
                        mem[reqAddr] = reqWData;
                        wrAddrQ.push_back(reqAddr);
                        wrDataQ.push_back(reqWData);
                    end
                    else
                    begin
                        i_memRData = mem[reqAddr];
                        rdAddrQ.push_back(reqAddr);
                    end
                end
            end
            if (o_memReq)
            begin
                busy     = 1'b1;
                reqWe    = o_memWe;
                reqAddr  = o_memAddr;
                reqWData = o_memWData;
                if (randLat)
                begin
                    lcgState = lcgNext(lcgState);
                    waitCnt  = 1 + int'(lcgState[17:16]);
                end
                else
                begin
                    waitCnt = 1;
                end
            end
        end
    end

    // LC-3 word built from the opcode and its fields
    function automatic logic [15:0] instr(input logic [3:0] op, input logic [2:0] hi,
                                          input logic [8:0] low);
        return {op, hi, low};
    endfunction

    function automatic logic [15:0] sext5(input logic [4:0] v);
        return {{11{v[4]}}, v};
    endfunction

    function automatic logic [8:0] offTo(input logic [15:0] target);
        logic [15:0] diff;
        diff = target - loadPc - 16'd1; // Relative to the incremented PC
        return diff[8:0];
    endfunction

    function automatic int replyCount(input bit writes);
        return writes ? wrAddrQ.size() : rdAddrQ.size();
    endfunction

    task automatic emit(input logic [15:0] word);
        mem[loadPc] = word;
        loadPc      = loadPc + 16'd1;
    endtask

    task automatic checkEq(input string name, input logic [15:0] act, input logic [15:0] exp);
        if (act !== exp)
        begin
            $display("mismatch %s: got 0x%04h, expected 0x%04h", name, act, exp);
            errCount++;
        end
    endtask

    task automatic checkWrite(input int idx, input logic [15:0] addr, input logic [15:0] data);
        checkEq("o_memAddr", wrAddrQ[idx], addr);
        checkEq("o_memWData", wrDataQ[idx], data);
    endtask

    // DUT stays in reset while memory and logs are cleared for program load
    task automatic beginTest(input bit randMode);
        errAtStart = errCount;
        @(negedge i_Clk);
        i_arstN = 1'b0;
        randLat = randMode;
        for (int a = 0; a < 65536; a++)
        begin
            mem[a] = {4'hD, a[11:0] ^ a[15:4]}; // Reserved opcode acts as a no-op
        end
        wrAddrQ.delete();
        wrDataQ.delete();
        rdAddrQ.delete();
        loadPc = `LC3_RESET_PC;
        repeat (2) @(negedge i_Clk);
    endtask

    task automatic waitReplies(input bit writes, input int count);
        int cycles;
        cycles  = 0;
        i_arstN = 1'b1;
        while ((replyCount(writes) < count) && (cycles < CyclesPerTest))
        begin
            @(posedge i_Clk);
            cycles++;
        end
        if (replyCount(writes) < count)
        begin
            $display("timeout: only %0d of %0d memory %s replies arrived",
                     replyCount(writes), count, writes ? "write" : "read");
            errCount++;
        end
    endtask

    task automatic endTest(input string name);
        string label;
        if (randLat)
        begin
            label = {name, " (random latency)"};
        end
        else
        begin
            label = name;
        end
        testCnt++;
        if (errCount == errAtStart)
        begin
            $display("%s: pass", label);
        end
        else
        begin
            $display("%s: FAIL with %0d errors", label, errCount - errAtStart);
            failCnt++;
        end
    endtask

    task automatic testFetchSequence();
        beginTest(1'b0);
        repeat (4) emit(instr(4'hD, 3'd0, 9'd0));
        waitReplies(1'b0, 3);
        for (int i = 0; i < 3; i++)
        begin
            checkEq("o_memAddr", rdAddrQ[i], `LC3_RESET_PC + 16'(i));
        end
        endTest("fetch sequence");
    endtask

    task automatic testOperate(input bit randMode);
        logic [15:0] r1;
        logic [15:0] expData [0:4];
        beginTest(randMode);
        r1         = 16'h0000 + sext5(5'd7);
        expData[0] = r1 + sext5(5'h1D);          // R2
        expData[1] = r1 + expData[0];            // R3
        expData[2] = expData[1] & sext5(5'd6);   // R4
        expData[3] = expData[1] & r1;            // R5
        expData[4] = ~expData[1];                // R6
        emit(instr(4'h1, 3'd1, {3'd0, 1'b1, 5'd7}));
        emit(instr(4'h1, 3'd2, {3'd1, 1'b1, 5'h1D}));
        emit(instr(4'h1, 3'd3, {3'd1, 3'b000, 3'd2}));
        emit(instr(4'h5, 3'd4, {3'd3, 1'b1, 5'd6}));
        emit(instr(4'h5, 3'd5, {3'd3, 3'b000, 3'd1}));
        emit(instr(4'h9, 3'd6, {3'd3, 6'h3F}));
        for (int i = 0; i < 5; i++)
        begin
            emit(instr(4'h3, 3'(i + 2), offTo(StoreBase + 16'(i))));
        end
        waitReplies(1'b1, 5);
        for (int i = 0; i < 5; i++)
        begin
            checkWrite(i, StoreBase + 16'(i), expData[i]);
        end
        endTest("operate");
    endtask

    task automatic testLoadStore(input bit randMode);
        beginTest(randMode);
        emit(instr(4'h2, 3'd1, offTo(DataAddr)));
        emit(instr(4'h3, 3'd1, offTo(StoreBase + 16'd1)));
        mem[DataAddr] = 16'hBEEF;
        waitReplies(1'b1, 1);
        checkWrite(0, StoreBase + 16'd1, 16'hBEEF);
        endTest("load and store");
    endtask

    task automatic testBranch(input bit randMode);
        beginTest(randMode);
        emit(instr(4'h1, 3'd1, {3'd0, 1'b1, 5'h1F})); // R1 = -1 sets n
        emit(instr(4'h0, 3'b010, 9'd1));              // BRz not taken
        emit(instr(4'h3, 3'd1, offTo(StoreBase)));
        emit(instr(4'h0, 3'b100, 9'd1));              // BRn taken
        emit(instr(4'h3, 3'd1, offTo(StoreBase + 16'd1)));
        emit(instr(4'h2, 3'd2, offTo(DataAddr)));     // R2 = 0 sets z
        emit(instr(4'h0, 3'b101, 9'd1));              // BRnp not taken
        emit(instr(4'h3, 3'd2, offTo(StoreBase + 16'd2)));
        emit(instr(4'h0, 3'b010, 9'd1));              // BRz taken
        emit(instr(4'h3, 3'd1, offTo(StoreBase + 16'd3)));
        emit(instr(4'h3, 3'd1, offTo(StoreBase + 16'd4)));
        emit(instr(4'h1, 3'd3, {3'd0, 1'b1, 5'd5}));  // R3 = 5 sets p
        emit(instr(4'h0, 3'b110, 9'd1));              // BRnz not taken
        emit(instr(4'h3, 3'd3, offTo(StoreBase + 16'd5)));
        emit(instr(4'h0, 3'b001, 9'd1));              // BRp taken
        emit(instr(4'h3, 3'd1, offTo(StoreBase + 16'd6)));
        emit(instr(4'h3, 3'd3, offTo(StoreBase + 16'd7)));
        mem[DataAddr] = 16'h0000;
        waitReplies(1'b1, 5);
        checkWrite(0, StoreBase, sext5(5'h1F));
        checkWrite(1, StoreBase + 16'd2, 16'h0000);
        checkWrite(2, StoreBase + 16'd4, sext5(5'h1F));
        checkWrite(3, StoreBase + 16'd5, sext5(5'd5));
        checkWrite(4, StoreBase + 16'd7, sext5(5'd5));
        endTest("branch");
    endtask

    task automatic testLeaJump(input bit randMode);
        logic [8:0]  off;
        logic [15:0] ea;
        beginTest(randMode);
        off = offTo(JumpTarget);
        ea  = `LC3_RESET_PC + 16'd1 + {{7{off[8]}}, off};
        emit(instr(4'hE, 3'd3, off));
        emit(instr(4'hC, 3'd0, {3'd3, 6'd0}));        // JMP R3
        loadPc = JumpTarget;
        emit(instr(4'h3, 3'd3, offTo(StoreBase)));
        waitReplies(1'b1, 1);
        checkEq("o_memAddr", rdAddrQ[2], ea);         // Fetch after the jump
        checkWrite(0, StoreBase, ea);
        endTest("lea and jump");
    endtask

    initial
    begin
        testFetchSequence();
        testOperate(1'b0);
        testLoadStore(1'b0);
        testBranch(1'b0);
        testLeaJump(1'b0);
        testOperate(1'b1);
        testLoadStore(1'b1);
        testBranch(1'b1);
        testLeaJump(1'b1);
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 testCnt, failCnt, errCount);
        if (errCount == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Budget covers every test at its worst-case length
    initial
    begin
        #(TestCnt * CyclesPerTest * ClkPeriod);
        $display("timeout: the run exceeded its cycle budget");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
lc3Pkg.sv
lc3RegFile.sv
lc3Datapath.sv
lc3Control.sv
lc3Core.sv
lc3Core_properties.sv
lc3CoreTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module lc3CoreTb -f build.f
	./obj_dir/Vlc3CoreTb | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
